// File: rtl/xlate_pkg.sv
// widths fixed at 32-bit data and 16-bit byte address, only word-aligned single transfers
package xlate_pkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int DATA_W     = 32;                // data bus
   localparam int BE_W       = DATA_W / 8;        // one enable per byte
   localparam int WORD_SHIFT = $clog2(BE_W);      // byte lanes within a word
   localparam int UAV_ADDR_W = 16;                // universal side, byte address
   localparam int AV_ADDR_W  = UAV_ADDR_W - WORD_SHIFT; // slave side, word address

   // ------------------------------------------------------------------------
   // payload types
   // ------------------------------------------------------------------------
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [BE_W-1:0]       be_t;
   typedef logic [UAV_ADDR_W-1:0] uav_addr_t;
   typedef logic [AV_ADDR_W-1:0]  av_addr_t;

   // word address of a byte address
   // low lane bits are dropped, the byteenables carry the lane select
   function automatic av_addr_t to_word_addr(input uav_addr_t byte_addr);
      av_addr_t word_addr;
      word_addr = byte_addr[UAV_ADDR_W-1:WORD_SHIFT];
      return word_addr;
   endfunction

endpackage

// File: rtl/slave_cmd_ctrl.sv
// master must hold read or write (never both) and all command fields while waitrequest is high
`timescale 1ns/100ps

module slave_cmd_ctrl
   import xlate_pkg::*;
#(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1
) (
   input  logic      clk,
   input  logic      reset,

   // universal side
   input  uav_addr_t uav_address,
   input  data_t     uav_writedata,
   input  be_t       uav_byteenable,
   input  logic      uav_read,
   input  logic      uav_write,
   output logic      uav_waitrequest,

   // to and from the read pipe
   output logic      read_accept,
   input  logic      reads_pending,

   // fixed-timing slave side
   output av_addr_t  av_address,
   output data_t     av_writedata,
   output be_t       av_byteenable,
   output be_t       av_writebyteenable,
   output logic      av_read,
   output logic      av_write,
   output logic      av_chipselect,
   output logic      av_begintransfer
);

   // count at which each kind of request is released
   localparam int READ_DONE  = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int WRITE_END  = SETUP_CYCLES + WRITE_WAIT_CYCLES;
   localparam int WRITE_DONE = WRITE_END + HOLD_CYCLES;
   localparam int MAX_COUNT  = (READ_DONE > WRITE_DONE) ? READ_DONE : WRITE_DONE;
   localparam int CNT_W      = (MAX_COUNT > 0) ? $clog2(MAX_COUNT + 1) : 1;

   localparam logic [CNT_W-1:0] SETUP_CNT      = CNT_W'(SETUP_CYCLES);
   localparam logic [CNT_W-1:0] READ_DONE_CNT  = CNT_W'(READ_DONE);
   localparam logic [CNT_W-1:0] WRITE_END_CNT  = CNT_W'(WRITE_END);
   localparam logic [CNT_W-1:0] WRITE_DONE_CNT = CNT_W'(WRITE_DONE);

   logic [CNT_W-1:0] wait_cnt;
   logic             reset_override;   // forces waitrequest in the cycle after reset
   logic             begin_done;       // begintransfer already given for this request
   logic             waitrequest_gen;
   logic             request;

   assign request = uav_read | uav_write;

   // ------------------------------------------------------------------------
   // address, data and byteenable mapping
   // ------------------------------------------------------------------------
   assign av_address         = to_word_addr(uav_address);
   assign av_writedata       = uav_writedata;
   assign av_byteenable      = uav_byteenable;
   assign av_writebyteenable = {BE_W{uav_write}} & uav_byteenable; // zero on reads

   // ------------------------------------------------------------------------
   // wait-state counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!uav_waitrequest || reset_override) begin
            wait_cnt <= '0;                    // restart after each accept
         end else if (request) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // strobes and generated waitrequest
   always_comb begin
      av_read  = uav_read && (wait_cnt >= SETUP_CNT);
      av_write = uav_write && (wait_cnt >= SETUP_CNT) && (wait_cnt <= WRITE_END_CNT);

      if (uav_write) begin
         waitrequest_gen = (wait_cnt != WRITE_DONE_CNT);   // through the hold cycles
      end else if (uav_read) begin
         waitrequest_gen = (wait_cnt != READ_DONE_CNT);
      end else begin
         waitrequest_gen = 1'b1;                           // idle
      end
   end

   assign uav_waitrequest = waitrequest_gen | reset_override;
   assign read_accept     = uav_read & ~uav_waitrequest;

   // ------------------------------------------------------------------------
   // begintransfer, one pulse in the first cycle of a request
   // ------------------------------------------------------------------------
   assign av_begintransfer = request & ~begin_done;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begin_done <= 1'b0;
      end else if (!uav_waitrequest) begin
         begin_done <= 1'b0;                    // accepted, next request starts fresh
      end else if (av_begintransfer) begin
         begin_done <= 1'b1;
      end
   end

   // chipselect held through the read latency
   assign av_chipselect = request | reads_pending;

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------
   a_one_command : assert property (
      @(posedge clk) disable iff (reset)
      !(uav_read && uav_write)
   ) else $error("read and write high together");

   // a stalled command must not move under the wait counter
   a_addr_held : assert property (
      @(posedge clk) disable iff (reset)
      (request && uav_waitrequest) |=> $stable(uav_address)
   ) else $error("address changed while waitrequest was high");

endmodule

// File: rtl/read_latency_pipe.sv
// READ_LATENCY must be 1 or more; readdata is taken from the slave in the readdatavalid cycle
`timescale 1ns/100ps

module read_latency_pipe
   import xlate_pkg::*;
#(
   parameter int READ_LATENCY = 2
) (
   input  logic  clk,
   input  logic  reset,

   // accept pulse from the command side
   input  logic  read_accept,

   // slave read data
   input  data_t av_readdata,

   // universal side response
   output logic  uav_readdatavalid,
   output data_t uav_readdata,

   // back to the command side for chipselect
   output logic  reads_pending
);

   // ------------------------------------------------------------------------
   // one bit per cycle of latency, oldest read in the top stage
   // ------------------------------------------------------------------------
   logic [READ_LATENCY-1:0] read_stage;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_stage <= '0;
      end else begin
         read_stage[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            read_stage[i] <= read_stage[i-1];   // back-to-back reads stay separate
         end
      end
   end

   assign uav_readdatavalid = read_stage[READ_LATENCY-1];

   // slave drives valid data exactly in the last stage cycle
   assign uav_readdata = av_readdata;

   // any read still on its way, last cycle included
   assign reads_pending = |read_stage;

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------

   // every valid goes back to an accept from the command side
   a_valid_has_accept : assert property (
      @(posedge clk) disable iff (reset)
      uav_readdatavalid |-> $past(read_accept, READ_LATENCY)
   ) else $error("readdatavalid without a matching accepted read");

   // slave has to have its word ready when valid goes out
   a_readdata_known : assert property (
      @(posedge clk) disable iff (reset)
      uav_readdatavalid |-> !$isunknown(av_readdata)
   ) else $error("slave read data unknown in the readdatavalid cycle");

endmodule

// File: rtl/slave_translator.sv
// fixed-timing slave only: no slave waitrequest, readdatavalid, bursts or unaligned access
`timescale 1ns/100ps

module slave_translator
   import xlate_pkg::*;
#(
   parameter int SETUP_CYCLES      = 1,   // before the strobe
   parameter int READ_WAIT_CYCLES  = 2,   // read strobe before accept
   parameter int WRITE_WAIT_CYCLES = 1,   // extra write strobe cycles
   parameter int HOLD_CYCLES       = 1,   // data held after the write strobe
   parameter int READ_LATENCY      = 2    // accept to readdatavalid, at least 1
) (
   input  logic      clk,
   input  logic      reset,

   // ------------------------------------------------------------------------
   // universal Avalon slave, from the master
   // ------------------------------------------------------------------------
   input  uav_addr_t uav_address,         // byte address
   input  data_t     uav_writedata,
   input  be_t       uav_byteenable,
   input  logic      uav_read,
   input  logic      uav_write,
   output logic      uav_waitrequest,
   output data_t     uav_readdata,
   output logic      uav_readdatavalid,

   // ------------------------------------------------------------------------
   // fixed-timing Avalon slave
   // ------------------------------------------------------------------------
   output av_addr_t  av_address,          // word address
   output data_t     av_writedata,
   output be_t       av_byteenable,
   output be_t       av_writebyteenable,
   output logic      av_read,
   output logic      av_write,
   output logic      av_chipselect,
   output logic      av_begintransfer,
   input  data_t     av_readdata
);

   logic read_accept;     // read taken this cycle
   logic reads_pending;   // reads waiting on their latency

   // ------------------------------------------------------------------------
   // command side: wait states, strobes, mapping
   // ------------------------------------------------------------------------
   slave_cmd_ctrl #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) u_cmd_ctrl (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_waitrequest    (uav_waitrequest),
      .read_accept        (read_accept),
      .reads_pending      (reads_pending),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_chipselect      (av_chipselect),
      .av_begintransfer   (av_begintransfer)
   );

   // ------------------------------------------------------------------------
   // response side: readdatavalid after the fixed latency
   // ------------------------------------------------------------------------
   read_latency_pipe #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_pipe (
      .clk               (clk),
      .reset             (reset),
      .read_accept       (read_accept),
      .av_readdata       (av_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata),
      .reads_pending     (reads_pending)
   );

endmodule

// File: test/fixed_slave_model.sv
// word memory of DEPTH words (power of two), word address wraps modulo DEPTH, no reset
`timescale 1ns/100ps

module fixed_slave_model
   import xlate_pkg::*;
#(
   parameter int READ_LATENCY = 2,
   parameter int DEPTH        = 1024
) (
   input  logic     clk,
   input  av_addr_t address,          // word address
   input  data_t    writedata,
   input  be_t      writebyteenable,
   input  logic     read,
   input  logic     write,
   input  logic     chipselect,
   output data_t    readdata
);

   localparam int IDX_W = $clog2(DEPTH);

   data_t            mem [DEPTH];
   data_t            read_pipe [READ_LATENCY];   // one word per cycle of latency
   logic [IDX_W-1:0] idx;

   assign idx = address[IDX_W-1:0];

   // preload, every word tied to its own index
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = {~16'(i), 16'(i)};
      end
   end

   // ------------------------------------------------------------------------
   // write port, byte lanes under writebyteenable
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      if (chipselect && write) begin
         for (int b = 0; b < BE_W; b++) begin
            if (writebyteenable[b]) begin
               mem[idx][8*b +: 8] <= writedata[8*b +: 8];
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // read port, data out READ_LATENCY cycles after the strobe is sampled
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      if (chipselect && read) begin
         read_pipe[0] <= mem[idx];
      end else begin
         read_pipe[0] <= '0;            // bus idles at zero
      end
      for (int i = 1; i < READ_LATENCY; i++) begin
         read_pipe[i] <= read_pipe[i-1];
      end
   end

   assign readdata = read_pipe[READ_LATENCY-1];

endmodule

// File: test/tb_slave_translator.sv
// directed tests at default timing; model aliases word addresses modulo MODEL_DEPTH
`timescale 1ns/100ps

module tb_slave_translator
   import xlate_pkg::*;
;

   localparam int SETUP_CYCLES      = 1;
   localparam int READ_WAIT_CYCLES  = 2;
   localparam int WRITE_WAIT_CYCLES = 1;
   localparam int HOLD_CYCLES       = 1;
   localparam int READ_LATENCY      = 2;

   localparam int          MODEL_DEPTH = 1024;
   localparam logic [31:0] TEST_SEED   = 32'h911af607;
   localparam int          N_RANDOM    = 40;
   localparam int          DRIVE_DELAY = 5;   // ns after the rising edge

   // cycle counts from the timing rules
   localparam int READ_ACCEPT_CYCLE   = SETUP_CYCLES + READ_WAIT_CYCLES + 1;
   localparam int WRITE_ACCEPT_CYCLE  = SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES + 1;
   localparam int READ_STROBE_CYCLES  = READ_WAIT_CYCLES + 1;
   localparam int WRITE_STROBE_CYCLES = WRITE_WAIT_CYCLES + 1;
   localparam int LONGEST_REQ         = (READ_ACCEPT_CYCLE > WRITE_ACCEPT_CYCLE) ?
                                        READ_ACCEPT_CYCLE : WRITE_ACCEPT_CYCLE;
   localparam int N_TRANSACTIONS      = N_RANDOM + 12;
   localparam int MAX_CYCLES          = 2 * N_TRANSACTIONS * (LONGEST_REQ + READ_LATENCY + 2);

   logic      clk;
   logic      reset;
   uav_addr_t uav_address;
   data_t     uav_writedata;
   be_t       uav_byteenable;
   logic      uav_read;
   logic      uav_write;
   logic      uav_waitrequest;
   data_t     uav_readdata;
   logic      uav_readdatavalid;
   av_addr_t  av_address;
   data_t     av_writedata;
   be_t       av_byteenable;
   be_t       av_writebyteenable;
   logic      av_read;
   logic      av_write;
   logic      av_chipselect;
   logic      av_begintransfer;
   data_t     av_readdata;

   data_t expected_mem [MODEL_DEPTH];   // scoreboard copy of the slave memory
   data_t expect_q[$];                  // read data in accept order
   int    accept_q[$];                  // cycle of each read accept
   int    next_check = 0;
   int    cycle_cnt  = 0;
   string current_test = "startup";

   slave_translator #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES),
      .READ_LATENCY      (READ_LATENCY)
   ) u_slave_translator (
      .clk (clk), .reset (reset),
      .uav_address (uav_address), .uav_writedata (uav_writedata),
      .uav_byteenable (uav_byteenable), .uav_read (uav_read), .uav_write (uav_write),
      .uav_waitrequest (uav_waitrequest), .uav_readdata (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .av_address (av_address), .av_writedata (av_writedata),
      .av_byteenable (av_byteenable), .av_writebyteenable (av_writebyteenable),
      .av_read (av_read), .av_write (av_write), .av_chipselect (av_chipselect),
      .av_begintransfer (av_begintransfer), .av_readdata (av_readdata)
   );

   fixed_slave_model #(
      .READ_LATENCY (READ_LATENCY),
      .DEPTH        (MODEL_DEPTH)
   ) u_slave_model (
      .clk (clk), .address (av_address), .writedata (av_writedata),
      .writebyteenable (av_writebyteenable), .read (av_read), .write (av_write),
      .chipselect (av_chipselect), .readdata (av_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   // ------------------------------------------------------------------------
   // failure reporting and compare tasks
   // ------------------------------------------------------------------------
   task automatic stop_on_failure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_data(input string what, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         stop_on_failure($sformatf("Error in %s, %s: expected %h, actual %h",
                                   current_test, what, expected, actual));
      end
   endtask

   task automatic check_addr(input string what, input av_addr_t expected,
                             input av_addr_t actual);
      if (actual !== expected) begin
         stop_on_failure($sformatf("Error in %s, %s: expected %h, actual %h",
                                   current_test, what, expected, actual));
      end
   endtask

   task automatic check_be(input string what, input be_t expected, input be_t actual);
      if (actual !== expected) begin
         stop_on_failure($sformatf("Error in %s, %s: expected %b, actual %b",
                                   current_test, what, expected, actual));
      end
   endtask

   task automatic check_count(input string what, input int expected, input int actual);
      if (actual != expected) begin
         stop_on_failure($sformatf("Error in %s, %s: expected %0d, actual %0d",
                                   current_test, what, expected, actual));
      end
   endtask

   // watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == MAX_CYCLES) begin
         stop_on_failure($sformatf("Timeout: run still going after %0d cycles", MAX_CYCLES));
      end
   end

   // read response monitor, latency and data against the scoreboard
   always @(negedge clk) begin
      if (!reset && uav_readdatavalid) begin
         if (next_check >= expect_q.size()) begin
            stop_on_failure("readdatavalid came with no read outstanding");
         end else begin
            check_count("read latency", READ_LATENCY, cycle_cnt - accept_q[next_check]);
            check_data("read data", expect_q[next_check], uav_readdata);
            next_check <= next_check + 1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic data_t fill_word(input int idx);
      return {~16'(idx), 16'(idx)};
   endfunction

   function automatic int word_index(input uav_addr_t addr);
      return int'(addr >> WORD_SHIFT) % MODEL_DEPTH;
   endfunction

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input be_t be);
      data_t merged;
      merged = old_word;
      for (int b = 0; b < BE_W; b++) begin
         if (be[b]) begin
            merged[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return merged;
   endfunction

   task automatic at_drive_point();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic drive_idle();
      uav_address    = '0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      at_drive_point();
      drive_idle();
      repeat (n - 1) @(posedge clk);
   endtask

   // one request held until accepted, checks the mapping every cycle
   task automatic run_request(input logic is_write, input uav_addr_t addr,
                              input data_t wdata, input be_t be, output int n_wait,
                              output int n_strobe, output int n_begin);
      int idx;
      idx = word_index(addr);
      at_drive_point();
      uav_address    = addr;
      uav_writedata  = wdata;
      uav_byteenable = be;
      uav_read       = !is_write;
      uav_write      = is_write;
      n_wait   = 0;
      n_strobe = 0;
      n_begin  = 0;
      do begin
         @(negedge clk);
         n_wait++;
         check_addr("word address", av_addr_t'(addr >> WORD_SHIFT), av_address);
         check_be("byteenable", be, av_byteenable);
         check_be("write byteenable", is_write ? be : '0, av_writebyteenable);
         check_count("chipselect during request", 1, int'(av_chipselect));
         check_count("opposite strobe", 0, int'(is_write ? av_read : av_write));
         if (is_write) begin
            check_data("write data", wdata, av_writedata);
         end
         if (is_write ? av_write : av_read) begin
            n_strobe++;
         end
         if (av_begintransfer) begin
            n_begin++;
         end
      end while (uav_waitrequest);
      if (is_write) begin
         expected_mem[idx] = merge_bytes(expected_mem[idx], wdata, be);
      end else begin
         expect_q.push_back(expected_mem[idx]);
         accept_q.push_back(cycle_cnt);
      end
   endtask

   task automatic drain_reads();
      at_drive_point();
      drive_idle();
      while (next_check < expect_q.size()) begin
         @(negedge clk);
      end
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic test_reset_state();
      current_test = "test_reset_state";
      repeat (3) begin
         @(negedge clk);
         check_count("waitrequest", 1, int'(uav_waitrequest));
         check_count("av_read", 0, int'(av_read));
         check_count("av_write", 0, int'(av_write));
         check_count("av_chipselect", 0, int'(av_chipselect));
         check_count("av_begintransfer", 0, int'(av_begintransfer));
         check_count("readdatavalid", 0, int'(uav_readdatavalid));
      end
   endtask

   task automatic test_address_map();
      int n_wait, n_strobe, n_begin;
      current_test = "test_address_map";
      run_request(1'b1, 16'hbeec, 32'h1357_9bdf, 4'b0110, n_wait, n_strobe, n_begin);
      idle_cycles(1);
      run_request(1'b0, 16'hbeec, '0, 4'b1111, n_wait, n_strobe, n_begin);
      idle_cycles(1);
      run_request(1'b1, 16'h8004, 32'hfeed_0042, 4'b1001, n_wait, n_strobe, n_begin);
      idle_cycles(2);
   endtask

   task automatic test_wait_timing();
      int n_wait, n_strobe, n_begin;
      current_test = "test_wait_timing";
      for (int k = 0; k < 2; k++) begin   // second one back to back
         run_request(1'b1, uav_addr_t'(16'h0040 + 4 * k), 32'ha5a5_0000, 4'b1111,
                     n_wait, n_strobe, n_begin);
         check_count("write accept cycle", WRITE_ACCEPT_CYCLE, n_wait);
         check_count("av_write cycles", WRITE_STROBE_CYCLES, n_strobe);
         check_count("begintransfer cycles", 1, n_begin);
      end
      for (int k = 0; k < 2; k++) begin
         run_request(1'b0, uav_addr_t'(16'h0040 + 4 * k), '0, 4'b1111,
                     n_wait, n_strobe, n_begin);
         check_count("read accept cycle", READ_ACCEPT_CYCLE, n_wait);
         check_count("av_read cycles", READ_STROBE_CYCLES, n_strobe);
         check_count("begintransfer cycles", 1, n_begin);
      end
      idle_cycles(READ_LATENCY + 1);
   endtask

   task automatic test_read_latency();
      int   n_wait, n_strobe, n_begin;
      int   n;
      logic seen;
      current_test = "test_read_latency";
      run_request(1'b1, 16'h0310, 32'hc0de_5a17, 4'b1111, n_wait, n_strobe, n_begin);
      idle_cycles(1);
      run_request(1'b0, 16'h0310, '0, 4'b1111, n_wait, n_strobe, n_begin);
      at_drive_point();
      drive_idle();
      n    = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk);
         n++;
         check_count("chipselect while read in flight", 1, int'(av_chipselect));
         seen = uav_readdatavalid;
      end
      check_count("cycles from accept to readdatavalid", READ_LATENCY, n);
      @(negedge clk);
      check_count("chipselect after read", 0, int'(av_chipselect));
   endtask

   task automatic test_random_traffic();
      logic      is_write;
      uav_addr_t addr;
      data_t     wdata;
      be_t       be;
      int        n_wait, n_strobe, n_begin;
      current_test = "test_random_traffic";
      for (int t = 0; t < N_RANDOM; t++) begin
         is_write = ($urandom % 2) == 0;
         addr     = uav_addr_t'($urandom);
         addr[WORD_SHIFT-1:0] = '0;          // word aligned only
         wdata    = $urandom;
         be       = be_t'($urandom);
         run_request(is_write, addr, wdata, be, n_wait, n_strobe, n_begin);
         check_count("accept cycle", is_write ? WRITE_ACCEPT_CYCLE : READ_ACCEPT_CYCLE, n_wait);
         check_count("begintransfer cycles", 1, n_begin);
         if ($urandom % 4 == 0) begin
            idle_cycles(int'(1 + $urandom % 3));
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      void'($urandom(TEST_SEED));
      for (int i = 0; i < MODEL_DEPTH; i++) begin
         expected_mem[i] = fill_word(i);
      end
      reset = 1'b1;
      drive_idle();
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      test_reset_state();
      test_address_map();
      test_wait_timing();
      test_read_latency();
      test_random_traffic();
      drain_reads();

      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: slave_translator.f
rtl/xlate_pkg.sv
rtl/slave_cmd_ctrl.sv
rtl/read_latency_pipe.sv
rtl/slave_translator.sv
test/fixed_slave_model.sv
test/tb_slave_translator.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the slave translator testbench
# exit status is non-zero when the testbench stops on a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_slave_translator \
   -f slave_translator.f \
   -o tb_slave_translator \
   && ./obj_dir/tb_slave_translator \
   || { echo "simulation did not pass"; exit 1; }
